/* hw/board_pkg.sv */
package board_pkg;

    // ============================================================
    // Bus and data widths.
    // ============================================================

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  irq_vector_t;
    typedef logic [15:0] gpio_t;
    typedef logic [1:0]  timer_index_t;

    // Size of a store on the store channel.
    typedef enum logic [1:0] {
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD
    } store_width_t;

    // ============================================================
    // Memory map.
    // ============================================================

    // I/O window, everything below it is data memory.
    localparam addr_t IO_START = 32'h0000_4000;
    localparam addr_t IO_END   = 32'h0000_41FF;

    // Timer registers, selected by address bits 3 to 2.
    localparam timer_index_t TIMER_COUNTER = 2'd0;
    localparam timer_index_t TIMER_COMPARE = 2'd1;
    localparam timer_index_t TIMER_CONTROL = 2'd2;

    // Vector reported for the timer, above the sixteen pins.
    localparam irq_vector_t TIMER_IRQ_VECTOR = 8'd16;

endpackage : board_pkg

/* hw/data_memory.sv */
module data_memory #(
    parameter int MEMORY_WORDS = 1024
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic                    load_request_i,
    input  board_pkg::addr_t        load_address_i,
    input  logic                    store_request_i,
    input  board_pkg::addr_t        store_address_i,
    input  board_pkg::word_t        store_data_i,
    input  board_pkg::store_width_t store_width_i,

    output board_pkg::word_t        load_data_o,
    output logic                    load_valid_o,
    output logic                    store_done_o
);

    localparam int INDEX_BITS = $clog2(MEMORY_WORDS);
    localparam board_pkg::addr_t MEMORY_BYTES = board_pkg::addr_t'(4 * MEMORY_WORDS);

    board_pkg::word_t memory [MEMORY_WORDS];
    board_pkg::word_t write_word;
    logic [3:0]       byte_enable;

    // Move the low bytes of the store data onto their lanes.
    always_comb begin
        byte_enable = 4'b1111;
        write_word  = store_data_i;
        case (store_width_i)
            board_pkg::STORE_BYTE: begin
                byte_enable = 4'b0001 << store_address_i[1:0];
                write_word  = store_data_i << {store_address_i[1:0], 3'b000};
            end
            board_pkg::STORE_HALF: begin
                byte_enable = 4'b0011 << {store_address_i[1], 1'b0};
                write_word  = store_data_i << {store_address_i[1], 4'b0000};
            end
            default: ;
        endcase
    end

    // A load in the same cycle as a store sees the old word.
    always_ff @(posedge clk_i) begin
        if (store_request_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_enable[lane]) begin
                    memory[store_address_i[INDEX_BITS+1:2]][lane*8 +: 8] <=
                        write_word[lane*8 +: 8];
                end
            end
        end
        if (load_request_i) begin
            load_data_o <= memory[load_address_i[INDEX_BITS+1:2]];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            load_valid_o <= 1'b0;
            store_done_o <= 1'b0;
        end else begin
            load_valid_o <= load_request_i;
            store_done_o <= store_request_i;
        end
    end

    // The arbiter must only route addresses that fall inside the array.
    request_in_range : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (load_request_i |-> load_address_i < MEMORY_BYTES) and
        (store_request_i |-> store_address_i < MEMORY_BYTES)
    );

endmodule : data_memory

/* hw/gpio_ports.sv */
module gpio_ports (
    input  logic             clk_i,
    input  logic             rst_n_i,

    input  board_pkg::gpio_t digital_i,
    input  board_pkg::gpio_t gpo_write_i,
    input  logic             gpo_data_i,

    output board_pkg::gpio_t gpi_sync_o,
    output board_pkg::gpio_t digital_o
);

    board_pkg::gpio_t sync_stage;

    // Two flops per pin against metastability.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_stage <= '0;
            gpi_sync_o <= '0;
        end else begin
            sync_stage <= digital_i;
            gpi_sync_o <= sync_stage;
        end
    end

    // Each output bit keeps its value until its own strobe.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            digital_o <= '0;
        end else begin
            for (int pin = 0; pin < 16; pin++) begin
                if (gpo_write_i[pin]) begin
                    digital_o[pin] <= gpo_data_i;
                end
            end
        end
    end

endmodule : gpio_ports

/* hw/mmio_timer.sv */
module mmio_timer (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic                    write_i,
    input  board_pkg::timer_index_t write_index_i,
    input  board_pkg::word_t        write_data_i,
    input  board_pkg::timer_index_t read_index_i,

    output board_pkg::word_t        read_data_o,
    output logic                    timer_irq_o
);

    board_pkg::word_t counter;
    board_pkg::word_t compare;
    board_pkg::word_t control;
    logic             enable;

    assign enable = control[0];

    // A register write overrides the count step in the same cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            counter <= '0;
            compare <= '0;
            control <= '0;
        end else begin
            if (enable) begin
                counter <= counter + 1'b1;
            end
            if (write_i) begin
                case (write_index_i)
                    board_pkg::TIMER_COUNTER: counter <= write_data_i;
                    board_pkg::TIMER_COMPARE: compare <= write_data_i;
                    board_pkg::TIMER_CONTROL: control <= write_data_i;
                    default: ;
                endcase
            end
        end
    end

    // Index 3 is unused and reads as zero.
    always_comb begin
        case (read_index_i)
            board_pkg::TIMER_COUNTER: read_data_o = counter;
            board_pkg::TIMER_COMPARE: read_data_o = compare;
            board_pkg::TIMER_CONTROL: read_data_o = control;
            default:                  read_data_o = '0;
        endcase
    end

    // Level stays high until disabled or the compare moves past the count.
    assign timer_irq_o = enable && (counter >= compare);

endmodule : mmio_timer

/* hw/interrupt_controller.sv */
module interrupt_controller (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  board_pkg::gpio_t       gpi_sync_i,
    input  logic                   timer_irq_i,
    input  logic                   interrupt_ackn_i,

    output logic                   interrupt_o,
    output logic                   timer_interrupt_o,
    output board_pkg::irq_vector_t interrupt_vector_o
);

    board_pkg::gpio_t gpi_prev;
    board_pkg::gpio_t gpi_edge;
    board_pkg::gpio_t pending;
    logic             timer_prev;
    logic             timer_edge;
    logic             timer_pending;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpi_prev   <= '0;
            timer_prev <= 1'b0;
        end else begin
            gpi_prev   <= gpi_sync_i;
            timer_prev <= timer_irq_i;
        end
    end

    assign gpi_edge   = gpi_sync_i & ~gpi_prev;
    assign timer_edge = timer_irq_i && !timer_prev;

    // Acknowledge beats any edge arriving in the same cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending       <= '0;
            timer_pending <= 1'b0;
        end else if (interrupt_ackn_i) begin
            pending       <= '0;
            timer_pending <= 1'b0;
        end else begin
            if (gpi_edge != '0) begin
                pending <= gpi_edge;
            end
            if (timer_edge) begin
                timer_pending <= 1'b1;
            end
        end
    end

    assign interrupt_o       = (pending != '0);
    assign timer_interrupt_o = timer_pending;

    // Timer first, then the highest pending pin.
    always_comb begin
        interrupt_vector_o = '0;
        if (timer_pending) begin
            interrupt_vector_o = board_pkg::TIMER_IRQ_VECTOR;
        end else begin
            for (int pin = 0; pin < 16; pin++) begin
                if (pending[pin]) begin
                    interrupt_vector_o = board_pkg::irq_vector_t'(pin);
                end
            end
        end
    end

    vector_in_range : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        interrupt_vector_o <= board_pkg::TIMER_IRQ_VECTOR
    );

endmodule : interrupt_controller

/* hw/bus_arbiter.sv */
module bus_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic                    store_request_i,
    input  board_pkg::addr_t        store_address_i,
    input  board_pkg::word_t        store_data_i,
    input  logic                    load_request_i,
    input  board_pkg::addr_t        load_address_i,

    input  board_pkg::word_t        mem_load_data_i,
    input  logic                    mem_load_valid_i,
    input  logic                    mem_store_done_i,
    input  board_pkg::word_t        timer_read_data_i,
    input  board_pkg::gpio_t        gpi_sync_i,
    input  board_pkg::gpio_t        gpo_state_i,

    output logic                    store_done_o,
    output board_pkg::word_t        load_data_o,
    output logic                    load_valid_o,
    output logic                    mem_load_request_o,
    output logic                    mem_store_request_o,
    output board_pkg::gpio_t        gpo_write_o,
    output logic                    gpo_data_o,
    output logic                    timer_write_o,
    output board_pkg::word_t        timer_write_data_o,
    output board_pkg::timer_index_t timer_write_index_o,
    output board_pkg::timer_index_t timer_read_index_o
);

    typedef enum logic {
        ARB_IDLE,
        ARB_WAIT_STORE
    } arb_state_t;

    arb_state_t state, state_next;
    logic       store_effective;
    logic       io_store_access;
    logic       io_load_access;
    logic       io_store_done;
    logic       io_load_valid;

    // ============================================================
    // Collision handling.
    // ============================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // The load wins a collision, the store is replayed next cycle.
    always_comb begin
        state_next      = ARB_IDLE;
        store_effective = store_request_i;
        case (state)
            ARB_IDLE: begin
                if (store_request_i && load_request_i) begin
                    state_next      = ARB_WAIT_STORE;
                    store_effective = 1'b0;
                end
            end
            ARB_WAIT_STORE: begin
                store_effective = 1'b1;
            end
        endcase
    end

    // ============================================================
    // Address decode and steering.
    // ============================================================

    assign io_store_access = (store_address_i >= board_pkg::IO_START) &&
                             (store_address_i <= board_pkg::IO_END);
    assign io_load_access  = (load_address_i >= board_pkg::IO_START) &&
                             (load_address_i <= board_pkg::IO_END);

    assign mem_store_request_o = store_effective && !io_store_access;
    assign mem_load_request_o  = load_request_i && !io_load_access;

    assign timer_write_data_o  = store_data_i;
    assign timer_write_index_o = store_address_i[3:2];
    assign timer_read_index_o  = load_address_i[3:2];
    assign gpo_data_o          = store_data_i[0];

    // Stores into the input window are accepted and dropped.
    always_comb begin
        gpo_write_o   = '0;
        timer_write_o = 1'b0;
        if (store_effective && io_store_access) begin
            if (store_address_i[8]) begin
                timer_write_o = 1'b1;
            end else if (!store_address_i[7]) begin
                gpo_write_o[store_address_i[5:2]] = 1'b1;
            end
        end
    end

    // I/O accesses answer one cycle after the request.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            io_store_done <= 1'b0;
            io_load_valid <= 1'b0;
        end else begin
            io_store_done <= store_effective && io_store_access;
            io_load_valid <= load_request_i && io_load_access;
        end
    end

    assign store_done_o = mem_store_done_i || io_store_done;
    assign load_valid_o = mem_load_valid_i || io_load_valid;

    // Read data follows the held load address.
    always_comb begin
        load_data_o = mem_load_data_i;
        if (io_load_access) begin
            if (load_address_i[8]) begin
                load_data_o = timer_read_data_i;
            end else if (load_address_i[7]) begin
                load_data_o = {31'b0, gpi_sync_i[load_address_i[5:2]]};
            end else begin
                load_data_o = {31'b0, gpo_state_i[load_address_i[5:2]]};
            end
        end
    end

    // Every done, from memory or I/O, answers a store issued the cycle before.
    done_follows_store : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        store_done_o |-> $past(store_effective)
    );

endmodule : bus_arbiter

/* hw/board.sv */
module board #(
    parameter int MEMORY_WORDS = 1024
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic                    store_request_i,
    input  board_pkg::addr_t        store_address_i,
    input  board_pkg::word_t        store_data_i,
    input  board_pkg::store_width_t store_width_i,
    output logic                    store_done_o,

    input  logic                    load_request_i,
    input  board_pkg::addr_t        load_address_i,
    output board_pkg::word_t        load_data_o,
    output logic                    load_valid_o,

    output logic                    interrupt_o,
    output logic                    timer_interrupt_o,
    output board_pkg::irq_vector_t  interrupt_vector_o,
    input  logic                    interrupt_ackn_i,

    input  board_pkg::gpio_t        digital_i,
    output board_pkg::gpio_t        digital_o
);

    // ============================================================
    // Reset synchronizer.
    // ============================================================

    logic rst_sync;
    logic rst_n;

    // Assert at once, release two edges after rst_n_i rises.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_sync <= 1'b0;
            rst_n    <= 1'b0;
        end else begin
            rst_sync <= 1'b1;
            rst_n    <= rst_sync;
        end
    end

    // ============================================================
    // Block interconnect.
    // ============================================================

    logic                    mem_load_request;
    logic                    mem_store_request;
    board_pkg::word_t        mem_load_data;
    logic                    mem_load_valid;
    logic                    mem_store_done;

    logic                    timer_write;
    board_pkg::timer_index_t timer_write_index;
    board_pkg::timer_index_t timer_read_index;
    board_pkg::word_t        timer_write_data;
    board_pkg::word_t        timer_read_data;
    logic                    timer_irq;

    board_pkg::gpio_t        gpo_write;
    logic                    gpo_data;
    board_pkg::gpio_t        gpi_sync;

    bus_arbiter i_bus_arbiter (
        .clk_i               ( clk_i             ),
        .rst_n_i             ( rst_n             ),
        .store_request_i     ( store_request_i   ),
        .store_address_i     ( store_address_i   ),
        .store_data_i        ( store_data_i      ),
        .load_request_i      ( load_request_i    ),
        .load_address_i      ( load_address_i    ),
        .mem_load_data_i     ( mem_load_data     ),
        .mem_load_valid_i    ( mem_load_valid    ),
        .mem_store_done_i    ( mem_store_done    ),
        .timer_read_data_i   ( timer_read_data   ),
        .gpi_sync_i          ( gpi_sync          ),
        .gpo_state_i         ( digital_o         ),
        .store_done_o        ( store_done_o      ),
        .load_data_o         ( load_data_o       ),
        .load_valid_o        ( load_valid_o      ),
        .mem_load_request_o  ( mem_load_request  ),
        .mem_store_request_o ( mem_store_request ),
        .gpo_write_o         ( gpo_write         ),
        .gpo_data_o          ( gpo_data          ),
        .timer_write_o       ( timer_write       ),
        .timer_write_data_o  ( timer_write_data  ),
        .timer_write_index_o ( timer_write_index ),
        .timer_read_index_o  ( timer_read_index  )
    );

    data_memory #(
        .MEMORY_WORDS ( MEMORY_WORDS )
    ) i_data_memory (
        .clk_i           ( clk_i             ),
        .rst_n_i         ( rst_n             ),
        .load_request_i  ( mem_load_request  ),
        .load_address_i  ( load_address_i    ),
        .store_request_i ( mem_store_request ),
        .store_address_i ( store_address_i   ),
        .store_data_i    ( store_data_i      ),
        .store_width_i   ( store_width_i     ),
        .load_data_o     ( mem_load_data     ),
        .load_valid_o    ( mem_load_valid    ),
        .store_done_o    ( mem_store_done    )
    );

    gpio_ports i_gpio_ports (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n     ),
        .digital_i   ( digital_i ),
        .gpo_write_i ( gpo_write ),
        .gpo_data_i  ( gpo_data  ),
        .gpi_sync_o  ( gpi_sync  ),
        .digital_o   ( digital_o )
    );

    mmio_timer i_mmio_timer (
        .clk_i         ( clk_i             ),
        .rst_n_i       ( rst_n             ),
        .write_i       ( timer_write       ),
        .write_index_i ( timer_write_index ),
        .write_data_i  ( timer_write_data  ),
        .read_index_i  ( timer_read_index  ),
        .read_data_o   ( timer_read_data   ),
        .timer_irq_o   ( timer_irq         )
    );

    interrupt_controller i_interrupt_controller (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n              ),
        .gpi_sync_i         ( gpi_sync           ),
        .timer_irq_i        ( timer_irq          ),
        .interrupt_ackn_i   ( interrupt_ackn_i   ),
        .interrupt_o        ( interrupt_o        ),
        .timer_interrupt_o  ( timer_interrupt_o  ),
        .interrupt_vector_o ( interrupt_vector_o )
    );

endmodule : board

/* test/board_tb.sv */
module board_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT  = 6000;
    localparam int WAIT_LIMIT   = 8;
    localparam int MODEL_WORDS  = 64;
    localparam int RESET_CYCLES = 16;

    localparam board_pkg::addr_t OUTPUT_BASE = 32'h0000_4000;
    localparam board_pkg::addr_t INPUT_BASE  = 32'h0000_4080;
    localparam board_pkg::addr_t TIMER_BASE  = 32'h0000_4100;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    store_request_i;
    board_pkg::addr_t        store_address_i;
    board_pkg::word_t        store_data_i;
    board_pkg::store_width_t store_width_i;
    logic                    store_done_o;
    logic                    load_request_i;
    board_pkg::addr_t        load_address_i;
    board_pkg::word_t        load_data_o;
    logic                    load_valid_o;
    logic                    interrupt_o;
    logic                    timer_interrupt_o;
    board_pkg::irq_vector_t  interrupt_vector_o;
    logic                    interrupt_ackn_i;
    board_pkg::gpio_t        digital_i;
    board_pkg::gpio_t        digital_o;

    int               errors = 0;
    int               checks = 0;
    int               cycle_count = 0;
    board_pkg::word_t rng_state = 32'd74927;
    board_pkg::word_t model_mem [MODEL_WORDS];

    board #(.MEMORY_WORDS(1024)) i_board (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // ============================================================
    // Helpers.
    // ============================================================

    function automatic board_pkg::word_t next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Expected word after a store of the given width lands on old.
    function automatic board_pkg::word_t merge_store(input board_pkg::word_t old,
            input board_pkg::addr_t addr, input board_pkg::word_t data,
            input board_pkg::store_width_t width);
        board_pkg::word_t merged;
        merged = old;
        case (width)
            board_pkg::STORE_BYTE: merged[8*addr[1:0] +: 8] = data[7:0];
            board_pkg::STORE_HALF: merged[16*addr[1] +: 16] = data[15:0];
            default:               merged = data;
        endcase
        return merged;
    endfunction

    function automatic int highest_index(input board_pkg::gpio_t bits);
        int index;
        index = 0;
        for (int pin = 0; pin < 16; pin++) begin
            if (bits[pin]) begin
                index = pin;
            end
        end
        return index;
    endfunction

    task automatic check_value(input string name, input board_pkg::word_t expected,
                               input board_pkg::word_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Latency counts cycles from the request cycle to the done pulse.
    task automatic do_store(input board_pkg::addr_t addr, input board_pkg::word_t data,
                            input board_pkg::store_width_t width, output int latency);
        logic done_seen;
        @(posedge clk_i);
        store_request_i <= 1'b1;
        store_address_i <= addr;
        store_data_i    <= data;
        store_width_i   <= width;
        @(posedge clk_i);
        store_request_i <= 1'b0;
        latency = 0;
        done_seen = 1'b0;
        while (!done_seen && latency < WAIT_LIMIT) begin
            @(negedge clk_i);
            latency++;
            done_seen = store_done_o;
            if (!done_seen) begin
                @(posedge clk_i);
            end
        end
        checks++;
        assert (done_seen) else begin
            $display("Store to address %h got no done pulse", addr);
            errors++;
        end
    endtask

    task automatic do_load(input board_pkg::addr_t addr, output board_pkg::word_t data,
                           output int latency);
        logic valid_seen;
        @(posedge clk_i);
        load_request_i <= 1'b1;
        load_address_i <= addr;
        @(posedge clk_i);
        load_request_i <= 1'b0;
        latency = 0;
        valid_seen = 1'b0;
        data = '0;
        while (!valid_seen && latency < WAIT_LIMIT) begin
            @(negedge clk_i);
            latency++;
            valid_seen = load_valid_o;
            data = load_data_o;
            if (!valid_seen) begin
                @(posedge clk_i);
            end
        end
        checks++;
        assert (valid_seen) else begin
            $display("Load from address %h got no valid pulse", addr);
            errors++;
        end
    endtask

    task automatic set_inputs(input board_pkg::gpio_t value);
        @(posedge clk_i);
        digital_i <= value;
    endtask

    task automatic pulse_ack();
        @(posedge clk_i);
        interrupt_ackn_i <= 1'b1;
        @(posedge clk_i);
        interrupt_ackn_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic wait_interrupt(input logic timer_line, input int limit);
        int   waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < limit) begin
            @(negedge clk_i);
            waited++;
            seen = timer_line ? timer_interrupt_o : interrupt_o;
        end
        checks++;
        assert (seen) else begin
            $display("Interrupt line (timer %0b) did not rise in %0d cycles", timer_line, limit);
            errors++;
        end
    endtask

    // ============================================================
    // Directed tests.
    // ============================================================

    task automatic memory_traffic();
        board_pkg::addr_t        addr;
        board_pkg::word_t        data;
        board_pkg::word_t        got;
        board_pkg::store_width_t width;
        int                      latency;
        // Fill the model region first since the array has no reset.
        for (int w = 0; w < MODEL_WORDS; w++) begin
            model_mem[w] = next_random();
            do_store(board_pkg::addr_t'(4 * w), model_mem[w], board_pkg::STORE_WORD, latency);
            check_value("store_done_o latency", 1, latency);
        end
        for (int n = 0; n < 120; n++) begin
            data  = next_random();
            width = board_pkg::store_width_t'(2'(next_random() % 3));
            addr  = next_random() % (4 * MODEL_WORDS);
            if (width == board_pkg::STORE_HALF) begin
                addr[0] = 1'b0;
            end else if (width == board_pkg::STORE_WORD) begin
                addr[1:0] = 2'b00;
            end
            do_store(addr, data, width, latency);
            check_value("store_done_o latency", 1, latency);
            model_mem[addr[31:2]] = merge_store(model_mem[addr[31:2]], addr, data, width);
            do_load({addr[31:2], 2'b00}, got, latency);
            check_value("load_valid_o latency", 1, latency);
            check_value("load_data_o", model_mem[addr[31:2]], got);
        end
    endtask

    task automatic collision_replay();
        board_pkg::word_t data;
        board_pkg::word_t got;
        int               latency;
        data = next_random();
        @(posedge clk_i);
        store_request_i <= 1'b1;
        store_address_i <= 32'h0000_0046;
        store_data_i    <= data;
        store_width_i   <= board_pkg::STORE_BYTE;
        load_request_i  <= 1'b1;
        load_address_i  <= 32'h0000_0044;
        @(posedge clk_i);
        store_request_i <= 1'b0;
        load_request_i  <= 1'b0;
        @(negedge clk_i);
        check_value("load_valid_o", 1, load_valid_o);
        check_value("load_data_o", model_mem[17], load_data_o);
        check_value("store_done_o", 0, store_done_o);
        @(negedge clk_i);
        check_value("store_done_o", 1, store_done_o);
        model_mem[17] = merge_store(model_mem[17], 32'h0000_0046, data, board_pkg::STORE_BYTE);
        do_load(32'h0000_0044, got, latency);
        check_value("load_data_o", model_mem[17], got);
    endtask

    task automatic output_pins();
        board_pkg::gpio_t expected;
        board_pkg::word_t data;
        board_pkg::word_t got;
        int               latency;
        expected = '0;
        for (int pin = 0; pin < 16; pin++) begin
            data = next_random();
            expected[pin] = data[0];
            do_store(OUTPUT_BASE + 4 * pin, data, board_pkg::STORE_WORD, latency);
            check_value("store_done_o latency", 1, latency);
            check_value("digital_o", expected, digital_o);
        end
        for (int pin = 0; pin < 16; pin++) begin
            do_load(OUTPUT_BASE + 4 * pin, got, latency);
            check_value("load_data_o", {31'b0, expected[pin]}, got);
        end
    endtask

    task automatic input_pins();
        board_pkg::gpio_t raised;
        board_pkg::word_t got;
        int               latency;
        raised = next_random() | 16'h0001;
        set_inputs(raised);
        wait_interrupt(1'b0, WAIT_LIMIT);
        check_value("interrupt_vector_o", highest_index(raised), interrupt_vector_o);
        for (int pin = 0; pin < 16; pin++) begin
            do_load(INPUT_BASE + 4 * pin, got, latency);
            check_value("load_data_o", {31'b0, raised[pin]}, got);
        end
        pulse_ack();
        check_value("interrupt_o", 0, interrupt_o);
        check_value("interrupt_vector_o", 0, interrupt_vector_o);
        set_inputs('0);
    endtask

    task automatic timer_compare();
        board_pkg::word_t got;
        int               latency;
        int               enable_cycle;
        int               elapsed;
        set_inputs(16'h0008);
        wait_interrupt(1'b0, WAIT_LIMIT);
        do_store(TIMER_BASE + 4 * board_pkg::TIMER_COMPARE, 50, board_pkg::STORE_WORD, latency);
        do_store(TIMER_BASE + 4 * board_pkg::TIMER_COUNTER, 0, board_pkg::STORE_WORD, latency);
        do_store(TIMER_BASE + 4 * board_pkg::TIMER_CONTROL, 1, board_pkg::STORE_WORD, latency);
        enable_cycle = cycle_count;
        do_load(TIMER_BASE + 4 * board_pkg::TIMER_COUNTER, got, latency);
        elapsed = cycle_count - enable_cycle;
        checks++;
        assert (got >= elapsed && got <= elapsed + 10) else begin
            $display("FAILED timer counter expected %h..%h actual %h", elapsed, elapsed + 10, got);
            errors++;
        end
        wait_interrupt(1'b1, 200);
        check_value("interrupt_o", 1, interrupt_o);
        check_value("interrupt_vector_o", 16, interrupt_vector_o);
        pulse_ack();
        check_value("timer_interrupt_o", 0, timer_interrupt_o);
        // A running timer would climb back past compare from zero.
        do_store(TIMER_BASE + 4 * board_pkg::TIMER_CONTROL, 0, board_pkg::STORE_WORD, latency);
        do_store(TIMER_BASE + 4 * board_pkg::TIMER_COUNTER, 0, board_pkg::STORE_WORD, latency);
        repeat (80) begin
            @(negedge clk_i);
            check_value("timer_interrupt_o", 0, timer_interrupt_o);
        end
        do_load(TIMER_BASE + 4 * board_pkg::TIMER_COUNTER, got, latency);
        check_value("timer counter", 0, got);
    endtask

    // ============================================================
    // Main sequence.
    // ============================================================

    initial begin
        board_pkg::word_t got;
        int               latency;
        rst_n_i          = 1'b0;
        store_request_i  = 1'b0;
        store_address_i  = '0;
        store_data_i     = '0;
        store_width_i    = board_pkg::STORE_WORD;
        load_request_i   = 1'b0;
        load_address_i   = '0;
        interrupt_ackn_i = 1'b0;
        digital_i        = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Internal reset lets go two edges later.
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check_value("store_done_o", 0, store_done_o);
        check_value("load_valid_o", 0, load_valid_o);
        check_value("interrupt_o", 0, interrupt_o);
        check_value("timer_interrupt_o", 0, timer_interrupt_o);
        check_value("interrupt_vector_o", 0, interrupt_vector_o);
        check_value("digital_o", 0, digital_o);
        do_load(TIMER_BASE + 4 * board_pkg::TIMER_COUNTER, got, latency);
        check_value("timer counter", 0, got);
        do_load(TIMER_BASE + 4 * board_pkg::TIMER_CONTROL, got, latency);
        check_value("timer control", 0, got);
        memory_traffic();
        collision_replay();
        output_pins();
        input_pins();
        timer_compare();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Run stopped after %0d cycles, checks %0d, errors %0d",
                 cycle_count, checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule : board_tb

/* board.f */
hw/board_pkg.sv
hw/data_memory.sv
hw/gpio_ports.sv
hw/mmio_timer.sv
hw/interrupt_controller.sv
hw/bus_arbiter.sv
hw/board.sv
test/board_tb.sv
